// ==== common/eth_tx_pkg.sv ====
// Widths assume 8-byte memory words narrowed to 2-byte beats; LANES must stay a power of two
`default_nettype none

package eth_tx_pkg;

    // Byte lanes on each side of the width adapter
    localparam int MEM_BYTES = 8;
    localparam int OUT_BYTES = 2;
    localparam int LANES     = MEM_BYTES / OUT_BYTES;
    localparam int LANE_W    = $clog2(LANES);

    typedef logic [15:0] addr_t;
    typedef logic [15:0] len_t;
    typedef logic [7:0]  tag_t;

    typedef logic [MEM_BYTES*8-1:0] mem_word_t;
    typedef logic [MEM_BYTES-1:0]   mem_keep_t;
    typedef logic [OUT_BYTES*8-1:0] out_word_t;
    typedef logic [OUT_BYTES-1:0]   out_keep_t;

    // Index of the beat within a memory word
    typedef logic [LANE_W-1:0] lane_t;

    // Transmit DMA sequencing
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_DATA,
        WAIT_SLOT,
        DONE
    } dma_state_t;

endpackage

`default_nettype wire

// ==== rtl/tx_dma/tx_desc_fsm.sv ====
// One read outstanding at a time; the next request waits until the adapter's holding register frees
`default_nettype none

module tx_desc_fsm (
    input  logic              logic_clk,
    input  logic              logic_rst,
    input  logic              tx_enable,

    input  logic              desc_valid,
    input  eth_tx_pkg::addr_t desc_addr,
    input  eth_tx_pkg::tag_t  desc_tag,
    input  logic              desc_user,
    output logic              desc_ready,
    output logic              len_load,

    output eth_tx_pkg::addr_t mem_rd_addr,
    output logic              mem_rd_valid,
    input  logic              mem_rd_ready,
    input  logic              mem_rd_data_valid,

    input  logic              word_last,
    input  logic              slot_free,
    input  logic              frame_sent,

    output eth_tx_pkg::tag_t  status_tag,
    output logic              status_valid,
    output logic              frame_user
);
    import eth_tx_pkg::*;

    dma_state_t state;
    addr_t      addr_q;
    tag_t       tag_q;
    logic       user_q;
    logic       desc_fire;
    logic       rd_fire;

    assign desc_ready = (state == IDLE) && tx_enable;
    assign desc_fire  = desc_valid && desc_ready;
    assign len_load   = desc_fire;

    // Once slot_free rises in FETCH it stays up until the request is taken
    assign mem_rd_valid = (state == FETCH) && slot_free;
    assign rd_fire      = mem_rd_valid && mem_rd_ready;
    assign mem_rd_addr  = addr_q;

    assign status_tag = tag_q;
    assign frame_user = user_q;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state        <= IDLE;
            status_valid <= 1'b0;
        end else begin
            status_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (desc_fire) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (rd_fire) begin
                        state <= WAIT_DATA;
                    end else if (!slot_free) begin
                        state <= WAIT_SLOT;
                    end
                end
                WAIT_DATA: begin
                    // Word loads the adapter in this same cycle
                    if (mem_rd_data_valid) begin
                        state <= word_last ? DONE : FETCH;
                    end
                end
                WAIT_SLOT: begin
                    if (slot_free) begin
                        state <= FETCH;
                    end
                end
                DONE: begin
                    if (frame_sent) begin
                        state        <= IDLE;
                        status_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Descriptor fields and the running fetch address
    always_ff @(posedge logic_clk) begin
        if (desc_fire) begin
            addr_q <= desc_addr;
            tag_q  <= desc_tag;
            user_q <= desc_user;
        end else if (rd_fire) begin
            addr_q <= addr_q + addr_t'(MEM_BYTES);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tx_dma/tx_len_counter.sv ====
// Assumes len_load and a returning word never coincide; keep masks are always a run from bit 0
`default_nettype none

module tx_len_counter (
    input  logic                  logic_clk,
    input  logic                  logic_rst,
    input  logic                  len_load,
    input  eth_tx_pkg::len_t      desc_len,
    input  logic                  mem_rd_data_valid,
    output eth_tx_pkg::mem_keep_t word_keep,
    output logic                  word_last
);
    import eth_tx_pkg::*;

    // Bytes not yet fetched, counting the word now arriving
    len_t remaining;

    assign word_last = (remaining <= len_t'(MEM_BYTES));

    // Keep bit i is set while more than i bytes remain
    always_comb begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            word_keep[i] = (remaining > len_t'(i));
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            remaining <= '0;
        end else if (len_load) begin
            remaining <= desc_len;
        end else if (mem_rd_data_valid) begin
            if (word_last) begin
                remaining <= '0;
            end else begin
                remaining <= remaining - len_t'(MEM_BYTES);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tx_dma/tx_width_adapter.sv ====
// Single holding register; a word may only arrive while slot_free is high, there is no response stall
`default_nettype none

module tx_width_adapter (
    input  logic                  logic_clk,
    input  logic                  logic_rst,

    input  eth_tx_pkg::mem_word_t mem_rd_data,
    input  logic                  mem_rd_data_valid,
    input  eth_tx_pkg::mem_keep_t word_keep,
    input  logic                  word_last,
    input  logic                  frame_user,

    output logic                  slot_free,
    output logic                  frame_sent,

    output eth_tx_pkg::out_word_t out_data,
    output eth_tx_pkg::out_keep_t out_keep,
    output logic                  out_last,
    output logic                  out_user,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import eth_tx_pkg::*;

    mem_word_t hold_data;
    mem_keep_t hold_keep;
    logic      hold_last;
    logic      hold_valid;
    lane_t     lane;
    logic      later_keep;
    logic      final_lane;
    logic      beat_fire;

    // Any kept byte in a lane above the current one
    always_comb begin
        later_keep = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            if (i > int'(lane) && |hold_keep[i*OUT_BYTES +: OUT_BYTES]) begin
                later_keep = 1'b1;
            end
        end
    end

    assign final_lane = !later_keep;
    assign beat_fire  = out_valid && out_ready;

    assign out_valid = hold_valid;
    assign out_data  = hold_data[lane*OUT_BYTES*8 +: OUT_BYTES*8];
    assign out_keep  = hold_keep[lane*OUT_BYTES +: OUT_BYTES];
    assign out_last  = hold_last && final_lane;
    assign out_user  = out_last && frame_user;

    assign slot_free  = !hold_valid || (beat_fire && final_lane);
    assign frame_sent = beat_fire && out_last;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            hold_valid <= 1'b0;
            hold_keep  <= '0;
            hold_last  <= 1'b0;
            lane       <= '0;
        end else begin
            if (beat_fire) begin
                if (final_lane) begin
                    hold_valid <= 1'b0;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
            // New word overrides the final beat's clear
            if (mem_rd_data_valid) begin
                hold_valid <= 1'b1;
                hold_keep  <= word_keep;
                hold_last  <= word_last;
                lane       <= '0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (mem_rd_data_valid) begin
            hold_data <= mem_rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/eth_tx_dma.sv ====
// Transmit DMA on logic_clk only; addresses must be 8-byte aligned and lengths at least one byte
`default_nettype none

module eth_tx_dma (
    input  logic                  logic_clk,
    input  logic                  logic_rst,
    input  logic                  tx_enable,

    // Descriptor input
    input  eth_tx_pkg::addr_t     desc_addr,
    input  eth_tx_pkg::len_t      desc_len,
    input  eth_tx_pkg::tag_t      desc_tag,
    input  logic                  desc_user,
    input  logic                  desc_valid,
    output logic                  desc_ready,

    // Memory read port
    output eth_tx_pkg::addr_t     mem_rd_addr,
    output logic                  mem_rd_valid,
    input  logic                  mem_rd_ready,
    input  eth_tx_pkg::mem_word_t mem_rd_data,
    input  logic                  mem_rd_data_valid,

    // Byte stream out
    output eth_tx_pkg::out_word_t out_data,
    output eth_tx_pkg::out_keep_t out_keep,
    output logic                  out_last,
    output logic                  out_user,
    output logic                  out_valid,
    input  logic                  out_ready,

    output eth_tx_pkg::tag_t      status_tag,
    output logic                  status_valid
);
    import eth_tx_pkg::*;

    logic      len_load;
    mem_keep_t word_keep;
    logic      word_last;
    logic      slot_free;
    logic      frame_sent;
    logic      frame_user;

    tx_desc_fsm tx_desc_fsm_inst (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .tx_enable         (tx_enable),
        .desc_valid        (desc_valid),
        .desc_addr         (desc_addr),
        .desc_tag          (desc_tag),
        .desc_user         (desc_user),
        .desc_ready        (desc_ready),
        .len_load          (len_load),
        .mem_rd_addr       (mem_rd_addr),
        .mem_rd_valid      (mem_rd_valid),
        .mem_rd_ready      (mem_rd_ready),
        .mem_rd_data_valid (mem_rd_data_valid),
        .word_last         (word_last),
        .slot_free         (slot_free),
        .frame_sent        (frame_sent),
        .status_tag        (status_tag),
        .status_valid      (status_valid),
        .frame_user        (frame_user)
    );

    tx_len_counter tx_len_counter_inst (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .len_load          (len_load),
        .desc_len          (desc_len),
        .mem_rd_data_valid (mem_rd_data_valid),
        .word_keep         (word_keep),
        .word_last         (word_last)
    );

    tx_width_adapter tx_width_adapter_inst (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .mem_rd_data       (mem_rd_data),
        .mem_rd_data_valid (mem_rd_data_valid),
        .word_keep         (word_keep),
        .word_last         (word_last),
        .frame_user        (frame_user),
        .slot_free         (slot_free),
        .frame_sent        (frame_sent),
        .out_data          (out_data),
        .out_keep          (out_keep),
        .out_last          (out_last),
        .out_user          (out_user),
        .out_valid         (out_valid),
        .out_ready         (out_ready)
    );

endmodule

`default_nettype wire

// ==== verif/eth_tx_dma_assert.sv ====
// Bound into eth_tx_dma; the state port is connected to the FSM instance inside the top level
`default_nettype none

module eth_tx_dma_assert (
    input logic                   logic_clk,
    input logic                   logic_rst,
    input logic                   desc_valid,
    input logic                   desc_ready,
    input logic                   mem_rd_valid,
    input logic                   mem_rd_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input eth_tx_pkg::out_word_t  out_data,
    input eth_tx_pkg::out_keep_t  out_keep,
    input logic                   status_valid,
    input eth_tx_pkg::dma_state_t state
);
    timeunit 1ns;
    timeprecision 100ps;
    import eth_tx_pkg::*;

    // Set from a descriptor transfer until its status pulse
    logic busy;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            busy <= 1'b0;
        end else if (desc_valid && desc_ready) begin
            busy <= 1'b1;
        end else if (status_valid) begin
            busy <= 1'b0;
        end
    end

    // Stalled beat stays put
    out_stable: assert property (@(posedge logic_clk) disable iff (logic_rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep))
        else $error("Output beat changed while out_ready was low");

    // Read request held until taken
    rd_held: assert property (@(posedge logic_clk) disable iff (logic_rst)
        mem_rd_valid && !mem_rd_ready |=> mem_rd_valid)
        else $error("mem_rd_valid dropped before mem_rd_ready");

    // FSM leaves IDLE for the whole frame, status pulse marks the return
    ready_in_idle: assert property (@(posedge logic_clk) disable iff (logic_rst)
        busy && !status_valid |-> state != IDLE && !desc_ready)
        else $error("desc_ready high or FSM in IDLE before the status pulse");

endmodule

`default_nettype wire

// ==== verif/eth_tx_dma_tb.sv ====
// Memory follows a fixed byte pattern; tx_enable is low only before the first descriptor
`default_nettype none

module eth_tx_dma_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import eth_tx_pkg::*;

    // Keep, last, user and data of one beat
    typedef logic [OUT_BYTES*8+OUT_BYTES+1:0] beat_t;

    logic      logic_clk = 1'b0;
    logic      logic_rst, tx_enable;
    addr_t     desc_addr, mem_rd_addr;
    len_t      desc_len;
    tag_t      desc_tag, status_tag;
    logic      desc_user, desc_valid, desc_ready;
    logic      mem_rd_valid, mem_rd_ready, mem_rd_data_valid;
    mem_word_t mem_rd_data;
    out_word_t out_data;
    out_keep_t out_keep;
    logic      out_last, out_user, out_valid, out_ready, status_valid;

    beat_t exp_beats[$];
    tag_t  exp_tags[$];
    string test_name = "reset";
    tag_t  next_tag = 8'h00;
    int    total_frames = 0;
    int    frames_done = 0;
    int    beat_count = 0;
    int    cycle_count = 0;
    int    cycle_limit;
    int    total_bytes;
    logic  last_fire_q = 1'b0;
    int    aligned_len[5] = '{8, 16, 24, 64, 40};
    int    rand_len[12];
    int    rand_addr[12];

    eth_tx_dma eth_tx_dma_inst (.*);

    bind eth_tx_dma eth_tx_dma_assert eth_tx_dma_assert_inst (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_ready (mem_rd_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .status_valid (status_valid),
        .state        (tx_desc_fsm_inst.state)
    );

    always #2 logic_clk = ~logic_clk;

    // Upper address byte folded in so every address bit shows in the data
    function automatic logic [7:0] mem_byte(input int a);
        int v;
        v = a * 7 + 3 + (a >> 8);
        return v[7:0];
    endfunction

    function automatic mem_word_t mem_word(input addr_t addr);
        mem_word_t w;
        for (int k = 0; k < MEM_BYTES; k++) begin
            w[k*8 +: 8] = mem_byte(int'(addr) + k);
        end
        return w;
    endfunction

    function automatic out_word_t data_mask(input out_keep_t keep);
        out_word_t m;
        for (int j = 0; j < OUT_BYTES; j++) begin
            m[j*8 +: 8] = {8{keep[j]}};
        end
        return m;
    endfunction

    // Reference beat list of one frame, unkept bytes read as zero
    function automatic void build_expected(input addr_t addr, input len_t len, input logic user);
        int        nbeats;
        out_keep_t keep;
        out_word_t data;
        logic      last;
        nbeats = (int'(len) + OUT_BYTES - 1) / OUT_BYTES;
        for (int i = 0; i < nbeats; i++) begin
            for (int j = 0; j < OUT_BYTES; j++) begin
                keep[j] = (i * OUT_BYTES + j) < int'(len);
                data[j*8 +: 8] = keep[j] ? mem_byte(int'(addr) + i * OUT_BYTES + j) : 8'h00;
            end
            last = (i == nbeats - 1);
            exp_beats.push_back({keep, last, last & user, data});
        end
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic send_desc(input addr_t addr, input len_t len, input logic user);
        build_expected(addr, len, user);
        exp_tags.push_back(next_tag);
        total_frames++;
        @(posedge logic_clk);
        #1;
        desc_addr  = addr;
        desc_len   = len;
        desc_tag   = next_tag;
        desc_user  = user;
        desc_valid = 1'b1;
        @(negedge logic_clk);
        while (!desc_ready) begin
            @(negedge logic_clk);
        end
        @(posedge logic_clk);
        #1;
        desc_valid = 1'b0;
        next_tag   = next_tag + 8'd1;
    endtask

    task automatic wait_frames();
        while (frames_done < total_frames) begin
            @(posedge logic_clk);
        end
    endtask

    // Memory read port, one word per request after 1 to 4 cycles
    initial begin : memory_model
        logic      req_fire;
        addr_t     req_addr;
        mem_word_t rd_word;
        logic      pending;
        int        wait_cnt;
        mem_rd_ready      = 1'b0;
        mem_rd_data       = '0;
        mem_rd_data_valid = 1'b0;
        pending           = 1'b0;
        wait_cnt          = 0;
        forever begin
            @(negedge logic_clk);
            req_fire = mem_rd_valid && mem_rd_ready;
            req_addr = mem_rd_addr;
            @(posedge logic_clk);
            #1;
            mem_rd_data_valid = 1'b0;
            if (req_fire) begin
                pending  = 1'b1;
                wait_cnt = $urandom_range(3, 0);
                rd_word  = mem_word(req_addr);
            end
            if (pending && wait_cnt == 0) begin
                mem_rd_data       = rd_word;
                mem_rd_data_valid = 1'b1;
                pending           = 1'b0;
            end else if (pending) begin
                wait_cnt--;
            end
            mem_rd_ready = ($urandom % 4) != 0;
        end
    end

    initial begin : sink_ready
        out_ready = 1'b0;
        forever begin
            @(posedge logic_clk);
            #1;
            out_ready = ($urandom % 3) != 0;
        end
    end

    // Compares beats and status pulses midway between edges
    always @(negedge logic_clk) begin : beat_compare
        beat_t expected;
        beat_t actual;
        if (!logic_rst) begin
            if (status_valid) begin
                assert (last_fire_q && exp_tags.size() > 0)
                    else report_failure($sformatf("Status pulse in %s without a finished frame",
                                                  test_name));
                assert (status_tag == exp_tags[0])
                    else report_failure($sformatf("Fail %s status_tag: expected %h actual %h",
                                                  test_name, exp_tags[0], status_tag));
                void'(exp_tags.pop_front());
                frames_done++;
            end else begin
                assert (!last_fire_q)
                    else report_failure($sformatf("No status pulse after the last beat in %s",
                                                  test_name));
            end
            if (!tx_enable) begin
                assert (!desc_ready && !out_valid)
                    else report_failure("Descriptor ready or beat sent while tx_enable was low");
            end
            if (out_valid) begin
                assert (out_keep != '0)
                    else report_failure($sformatf("Empty beat offered in %s", test_name));
            end
            if (out_valid && out_ready) begin
                assert (exp_beats.size() > 0)
                    else report_failure($sformatf("Beat in %s with no frame expected", test_name));
                expected = exp_beats.pop_front();
                actual   = {out_keep, out_last, out_user, out_data & data_mask(out_keep)};
                assert (actual == expected)
                    else report_failure($sformatf("Fail %s beat %0d: expected %h actual %h",
                                                  test_name, beat_count, expected, actual));
                beat_count++;
            end
            last_fire_q = out_valid && out_ready && out_last;
        end
    end

    always @(posedge logic_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            report_failure($sformatf("Timeout after %0d cycles with %0d frames not finished",
                                     cycle_count, total_frames - frames_done));
        end
    end

    initial begin
        void'($urandom(32'hc8805797));
        logic_rst   = 1'b1;
        tx_enable   = 1'b0;
        desc_addr   = '0;
        desc_len    = len_t'(16);
        desc_tag    = '0;
        desc_user   = 1'b0;
        desc_valid  = 1'b0;
        total_bytes = 276;
        foreach (aligned_len[i]) begin
            total_bytes += aligned_len[i];
        end
        for (int i = 0; i < 12; i++) begin
            rand_len[i]  = int'($urandom_range(48, 1));
            rand_addr[i] = 16384 + 8 * int'($urandom_range(255, 0));
            total_bytes += rand_len[i];
        end
        cycle_limit = total_bytes * 8 + 2000;

        repeat (3) @(posedge logic_clk);
        #1;
        logic_rst = 1'b0;
        @(negedge logic_clk);
        assert (!desc_ready && !mem_rd_valid && !out_valid && !status_valid)
            else report_failure("Handshake outputs not low after reset");

        // Offered descriptor is ignored while disabled
        test_name = "disabled";
        @(posedge logic_clk);
        #1;
        desc_valid = 1'b1;
        repeat (8) @(posedge logic_clk);
        #1;
        desc_valid = 1'b0;
        tx_enable  = 1'b1;

        test_name = "aligned";
        foreach (aligned_len[i]) begin
            send_desc(addr_t'(64 + 256 * i), len_t'(aligned_len[i]), (i % 2) == 1);
        end
        wait_frames();

        // Lengths 1 to 23 sum to 276 bytes
        test_name = "partial";
        for (int len = 1; len <= 23; len++) begin
            send_desc(addr_t'(8192 + 64 * len), len_t'(len), (len % 3) == 0);
        end
        wait_frames();

        test_name = "random";
        for (int i = 0; i < 12; i++) begin
            send_desc(addr_t'(rand_addr[i]), len_t'(rand_len[i]), (rand_len[i] % 2) == 1);
        end
        wait_frames();

        assert (exp_beats.size() == 0)
            else report_failure("Expected beats left over at the end of the run");
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
common/eth_tx_pkg.sv
rtl/tx_dma/tx_desc_fsm.sv
rtl/tx_dma/tx_len_counter.sv
rtl/tx_dma/tx_width_adapter.sv
rtl/eth_tx_dma.sv
verif/eth_tx_dma_assert.sv
verif/eth_tx_dma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and exits non-zero unless the run passed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module eth_tx_dma_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Veth_tx_dma_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF ">>> PASS"; then
    exit 0
fi
exit 1
